//--- common/cpuPkg.sv
package cpuPkg;

    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH = 4;
    localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;
    typedef logic [4:0] regIdxT;
    typedef logic [$clog2(ROB_DEPTH)-1:0] robTagT;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } opT;

    typedef struct packed {
        logic   ready;
        robTagT tag;    // producer, while not ready.
        dataT   value;
    } srcT;

    typedef struct packed {
        opT     op;
        addrT   pc;
        dataT   imm;
        regIdxT rd;
        logic   hasRd;
        srcT    src1;
        srcT    src2;
    } dispatchT;

    typedef struct packed {
        logic hit;
        dataT value;
    } fwdT;

    typedef struct packed {
        fwdT src1;
        fwdT src2;
    } robSrcT;

    typedef struct packed {
        opT     op;
        addrT   pc;
        dataT   imm;
        dataT   rs1Val;
        dataT   rs2Val;
        robTagT tag;
    } issueT;

    typedef struct packed {
        logic   valid;
        robTagT tag;
        dataT   value;
        logic   jump;
        addrT   jumpPc;
    } cdbT;

    typedef struct packed {
        robTagT tag;
        regIdxT rd;
        logic   hasRd;
        dataT   value;
        logic   jump;
        addrT   jumpPc;
    } commitT;

endpackage

//--- dv/aluClusterTb.sv
`timescale 1ns/100ps

module aluClusterTb
    import cpuPkg::*;
();

    localparam int NUM_INSTR = 400;

    logic     clk;
    logic     rst;
    logic     dispValid;
    dispatchT disp;
    logic     dispReady;
    robTagT   dispTag;
    logic     commitReady;
    logic     commitValid;
    commitT   commit;
    logic     redirectValid;
    addrT     redirectPc;

    logic [31:0] lcgState = 32'hd1ca4ea2;
    dataT        archReg [32];
    dataT        specReg [32];
    robTagT      regTag [32];
    logic        pending [32];
    commitT      expQ [$];
    int          dispatched = 0;
    int          outstanding = 0;
    int          stallLeft = 0;
    int          errors = 0;
    logic        needNew = 1'b1;
    opT          curOp;
    addrT        curPc;
    addrT        nextPc = 32'h0000_1000;
    dataT        curImm;
    regIdxT      curRd;
    regIdxT      curRs1;
    regIdxT      curRs2;

    aluCluster u_aluCluster (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(string why);
        errors++;
        $display("At %0d ns: %s", $time, why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // program-order result of one instruction.
    function automatic commitT refExec(opT op, addrT pc, dataT imm, dataT a, dataT b);
        commitT r;
        r = '0;
        r.jumpPc = pc + imm;
        case (op)
            OP_LUI:   r.value = imm;
            OP_AUIPC: r.value = pc + imm;
            OP_JAL:   {r.jump, r.value} = {1'b1, pc + 32'd4};
            OP_JALR: begin
                {r.jump, r.value} = {1'b1, pc + 32'd4};
                r.jumpPc = {a[31:1] + imm[31:1] + 31'(a[0] & imm[0]), 1'b0};
            end
            OP_BEQ:   r.jump = a == b;
            OP_BNE:   r.jump = a != b;
            OP_BLT:   r.jump = $signed(a) < $signed(b);
            OP_BGE:   r.jump = !($signed(a) < $signed(b));
            OP_BLTU:  r.jump = a < b;
            OP_BGEU:  r.jump = !(a < b);
            OP_ADDI:  r.value = a + imm;
            OP_SLTI:  r.value = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            OP_SLTIU: r.value = (a < imm) ? 32'd1 : 32'd0;
            OP_XORI:  r.value = a ^ imm;
            OP_ORI:   r.value = a | imm;
            OP_ANDI:  r.value = a & imm;
            OP_SLLI:  r.value = a << imm[4:0];
            OP_SRLI:  r.value = a >> imm[4:0];
            OP_SRAI:  r.value = dataT'($signed(a) >>> imm[4:0]);
            OP_ADD:   r.value = a + b;
            OP_SUB:   r.value = a - b;
            OP_SLL:   r.value = a << b[4:0];
            OP_SLT:   r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:  r.value = (a < b) ? 32'd1 : 32'd0;
            OP_XOR:   r.value = a ^ b;
            OP_SRL:   r.value = a >> b[4:0];
            OP_SRA:   r.value = dataT'($signed(a) >>> b[4:0]);
            OP_OR:    r.value = a | b;
            OP_AND:   r.value = a & b;
            default:  r.value = '0;
        endcase
        return r;
    endfunction

    // ready value from the register file, else the producer's tag.
    function automatic srcT buildSrc(regIdxT r);
        srcT s;
        s = '0;
        s.ready = (r == 0) || !pending[r];
        s.tag = regTag[r];
        s.value = (r == 0) ? '0 : archReg[r];
        return s;
    endfunction

    task automatic pickInstr();
        int sel;
        sel = int'(nextRand() % 64);
        curPc = nextPc;
        curRs1 = regIdxT'(nextRand() % 8);
        curRs2 = regIdxT'(nextRand() % 8);
        curRd = regIdxT'(nextRand() % 8);
        curImm = dataT'({{20{lcgState[27]}}, lcgState[27:16]});
        if (sel < 3) begin
            curOp = (sel == 0) ? OP_LUI : OP_AUIPC;
            curImm = {nextRand() & 32'hffff_f000};
        end else if (sel < 5) begin
            curOp = (sel == 3) ? OP_JAL : OP_JALR;
            curRd = regIdxT'(1 + nextRand() % 7);
            curImm = dataT'((int'(nextRand() % 16) - 8) * 4);
        end else if (sel < 12) begin
            curOp = opT'(int'(OP_BEQ) + int'(nextRand() % 6));
            curRd = '0;
            curImm = dataT'((int'(nextRand() % 16) - 8) * 4);
        end else begin
            curOp = opT'(int'(OP_ADDI) + int'(nextRand() % 19));
        end
    endtask

    always @(posedge clk) begin
        commitT exp;
        commitT res;
        logic   hasRd;
        if (!rst) begin
            if (commitValid && commitReady) begin
                assert (expQ.size() > 0)
                    else abortRun("an instruction retired that was never dispatched");
                exp = expQ.pop_front();
                assert (commit.tag == exp.tag)
                    else reportMismatch("commit.tag", 32'(commit.tag), 32'(exp.tag));
                assert (commit.rd == exp.rd)
                    else reportMismatch("commit.rd", 32'(commit.rd), 32'(exp.rd));
                assert (commit.hasRd == exp.hasRd)
                    else reportMismatch("commit.hasRd", 32'(commit.hasRd), 32'(exp.hasRd));
                assert (!exp.hasRd || commit.value == exp.value)
                    else reportMismatch("commit.value", commit.value, exp.value);
                assert (commit.jump == exp.jump)
                    else reportMismatch("commit.jump", 32'(commit.jump), 32'(exp.jump));
                assert (!exp.jump || commit.jumpPc == exp.jumpPc)
                    else reportMismatch("commit.jumpPc", commit.jumpPc, exp.jumpPc);
                assert (redirectValid == exp.jump)
                    else reportMismatch("redirectValid", 32'(redirectValid), 32'(exp.jump));
                assert (!exp.jump || redirectPc == exp.jumpPc)
                    else reportMismatch("redirectPc", redirectPc, exp.jumpPc);
                if (exp.hasRd) begin
                    archReg[exp.rd] = exp.value;
                    if (pending[exp.rd] && regTag[exp.rd] == exp.tag) begin
                        pending[exp.rd] = 1'b0;
                    end
                end
                if (exp.jump) begin    // wrong path is gone.
                    expQ.delete();
                    for (int i = 0; i < 32; i++) begin
                        pending[i] = 1'b0;
                        specReg[i] = archReg[i];
                    end
                    nextPc = exp.jumpPc;
                    needNew = 1'b1;
                end
            end else begin
                assert (!redirectValid)
                    else abortRun("redirect raised while no instruction retired");
            end
            if (dispValid && dispReady) begin
                hasRd = (curRd != 0) && !(curOp inside {[OP_BEQ:OP_BGEU]});
                res = refExec(curOp, curPc, curImm, specReg[curRs1], specReg[curRs2]);
                res.tag = dispTag;
                res.rd = hasRd ? curRd : '0;
                res.hasRd = hasRd;
                expQ.push_back(res);
                if (hasRd) begin
                    specReg[curRd] = res.value;
                    regTag[curRd] = dispTag;
                    pending[curRd] = 1'b1;
                end
                dispatched++;
                nextPc = curPc + 32'd4;    // predicted not-taken.
                needNew = 1'b1;
            end
            outstanding = expQ.size();
            if (needNew && dispatched < NUM_INSTR && nextRand() % 4 != 0) begin
                pickInstr();
                needNew = 1'b0;
            end
            dispValid <= !needNew;
            disp <= '{op: curOp, pc: curPc, imm: curImm, rd: curRd,
                      hasRd: curRd != 0 && !(curOp inside {[OP_BEQ:OP_BGEU]}),
                      src1: buildSrc(curRs1), src2: buildSrc(curRs2)};
            if (stallLeft > 0) begin
                stallLeft--;
                commitReady <= 1'b0;
            end else if (nextRand() % 16 == 0) begin
                stallLeft = int'(nextRand() % 15);
                commitReady <= 1'b0;
            end else begin
                commitReady <= 1'b1;
            end
        end
    end

    commitHoldA: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady |=> commitValid && $stable(commit))
        else abortRun("commit changed while commitReady was low");

    robFullA: assert property (@(posedge clk) disable iff (rst)
        outstanding >= ROB_DEPTH |-> !dispReady)
        else abortRun("dispReady stayed high with the reorder buffer full");

    initial begin
        #(NUM_INSTR * 40 * 4);
        $display("Watchdog expired after %0d ns with instructions still pending", $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        for (int i = 0; i < 32; i++) begin
            archReg[i] = '0;
            specReg[i] = '0;
            regTag[i] = '0;
            pending[i] = 1'b0;
        end
        rst = 1'b1;
        dispValid = 1'b0;
        disp = '0;
        commitReady = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!commitValid && !redirectValid && dispReady)
            else abortRun("outputs not idle after reset");
        while (!(dispatched >= NUM_INSTR && expQ.size() == 0 && !dispValid)) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

//--- flist.f
common/cpuPkg.sv
resStation/resStation.sv
rtl/execute.sv
reorderBuffer/reorderBuffer.sv
rtl/aluCluster.sv
dv/aluClusterTb.sv

//--- reorderBuffer/reorderBuffer.sv
`timescale 1ns/100ps

module reorderBuffer
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dispValid,
    input  dispatchT disp,
    input  logic     rsFull,
    output logic     dispReady,
    output robTagT   dispTag,
    output logic     alloc,
    output robSrcT   robSrc,
    input  cdbT      cdb,
    input  logic     commitReady,
    output logic     commitValid,
    output commitT   commit,
    output logic     flush,
    output logic     redirectValid,
    output addrT     redirectPc
);

    typedef struct packed {
        regIdxT rd;
        logic   hasRd;
        dataT   value;
        logic   jump;
        addrT   jumpPc;
    } robEntryT;

    robEntryT             ent [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    robTagT               head;
    robTagT               tail;
    logic [ROB_CNT_W-1:0] count;
    logic                 full;
    logic                 retire;

    assign full = count == ROB_CNT_W'(ROB_DEPTH);
    assign dispReady = !full && !rsFull && !flush;    // nothing enters behind a redirect.
    assign dispTag = tail;
    assign alloc = dispValid && dispReady;

    // finished but not yet retired values.
    always_comb begin
        robSrc.src1.hit = busy[disp.src1.tag] && done[disp.src1.tag];
        robSrc.src1.value = ent[disp.src1.tag].value;
        robSrc.src2.hit = busy[disp.src2.tag] && done[disp.src2.tag];
        robSrc.src2.value = ent[disp.src2.tag].value;
    end

    assign commitValid = busy[head] && done[head];
    assign retire = commitValid && commitReady;

    always_comb begin
        commit.tag = head;
        commit.rd = ent[head].rd;
        commit.hasRd = ent[head].hasRd;
        commit.value = ent[head].value;
        commit.jump = ent[head].jump;
        commit.jumpPc = ent[head].jumpPc;
    end

    assign flush = retire && ent[head].jump;
    assign redirectValid = flush;
    assign redirectPc = ent[head].jumpPc;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            busy <= '0;
            done <= '0;
        end else begin
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + ROB_CNT_W'(alloc) - ROB_CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent[tail].rd <= disp.rd;
            ent[tail].hasRd <= disp.hasRd;
        end
        if (cdb.valid) begin
            ent[cdb.tag].value <= cdb.value;
            ent[cdb.tag].jump <= cdb.jump;
            ent[cdb.tag].jumpPc <= cdb.jumpPc;
        end
    end

    allocNotFullA: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !busy[tail]);

    // each allocated entry is written back exactly once.
    cdbLiveEntryA: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> busy[cdb.tag] && !done[cdb.tag]);

    commitHoldA: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady |=> commitValid && $stable(commit));

endmodule

//--- resStation/resStation.sv
`timescale 1ns/100ps

module resStation
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  robTagT   allocTag,
    input  dispatchT disp,
    input  robSrcT   robSrc,
    input  cdbT      cdb,
    input  logic     flush,
    output logic     rsFull,
    output logic     issueValid,
    output issueT    issue
);

    typedef struct packed {
        opT     op;
        addrT   pc;
        dataT   imm;
        robTagT tag;
        srcT    src1;
        srcT    src2;
    } rsEntryT;

    rsEntryT             slot [RS_DEPTH];
    logic [RS_DEPTH-1:0] valid;
    logic [RS_DEPTH-1:0] readyVec;
    logic [RS_IDX_W-1:0] issueIdx;
    logic [RS_IDX_W-1:0] freeIdx;

    // snoop the bus for a waiting operand.
    function automatic srcT wakeSrc(srcT s, cdbT bus);
        srcT r;
        r = s;
        if (!s.ready && bus.valid && bus.tag == s.tag) begin
            r.ready = 1'b1;
            r.value = bus.value;
        end
        return r;
    endfunction

    // dispatcher value first, then rob forward, then the bus.
    function automatic srcT captureSrc(srcT s, fwdT fwd, cdbT bus);
        srcT r;
        r = s;
        if (!s.ready && fwd.hit) begin
            r.ready = 1'b1;
            r.value = fwd.value;
        end else begin
            r = wakeSrc(s, bus);
        end
        return r;
    endfunction

    always_comb begin
        issueIdx = '0;
        freeIdx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            readyVec[i] = valid[i] && slot[i].src1.ready && slot[i].src2.ready;
            if (readyVec[i]) begin
                issueIdx = RS_IDX_W'(i);    // lowest index wins.
            end
            if (!valid[i]) begin
                freeIdx = RS_IDX_W'(i);
            end
        end
    end

    assign rsFull = &valid;
    assign issueValid = |readyVec;

    always_comb begin
        issue.op = slot[issueIdx].op;
        issue.pc = slot[issueIdx].pc;
        issue.imm = slot[issueIdx].imm;
        issue.rs1Val = slot[issueIdx].src1.value;
        issue.rs2Val = slot[issueIdx].src2.value;
        issue.tag = slot[issueIdx].tag;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else begin
            if (issueValid) begin
                valid[issueIdx] <= 1'b0;
            end
            if (alloc) begin
                valid[freeIdx] <= 1'b1;    // never the issuing slot.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot[i].src1 <= wakeSrc(slot[i].src1, cdb);
            slot[i].src2 <= wakeSrc(slot[i].src2, cdb);
        end
        if (alloc) begin
            slot[freeIdx].op <= disp.op;
            slot[freeIdx].pc <= disp.pc;
            slot[freeIdx].imm <= disp.imm;
            slot[freeIdx].tag <= allocTag;
            slot[freeIdx].src1 <= captureSrc(disp.src1, robSrc.src1, cdb);
            slot[freeIdx].src2 <= captureSrc(disp.src2, robSrc.src2, cdb);
        end
    end

    // no alloc when the dispatch side sees us full.
    allocSpaceA: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !rsFull);

endmodule

//--- rtl/aluCluster.sv
`timescale 1ns/100ps

module aluCluster
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dispValid,
    input  dispatchT disp,
    output logic     dispReady,
    output robTagT   dispTag,
    input  logic     commitReady,
    output logic     commitValid,
    output commitT   commit,
    output logic     redirectValid,
    output addrT     redirectPc
);

    logic   alloc;
    logic   rsFull;
    logic   flush;
    logic   issueValid;
    issueT  issue;
    robSrcT robSrc;
    cdbT    cdb;

    resStation u_resStation (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .allocTag   (dispTag),
        .disp       (disp),
        .robSrc     (robSrc),
        .cdb        (cdb),
        .flush      (flush),
        .rsFull     (rsFull),
        .issueValid (issueValid),
        .issue      (issue)
    );

    execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issueValid (issueValid),
        .issue      (issue),
        .cdb        (cdb)
    );

    reorderBuffer u_reorderBuffer (
        .clk           (clk),
        .rst           (rst),
        .dispValid     (dispValid),
        .disp          (disp),
        .rsFull        (rsFull),
        .dispReady     (dispReady),
        .dispTag       (dispTag),
        .alloc         (alloc),
        .robSrc        (robSrc),
        .cdb           (cdb),
        .commitReady   (commitReady),
        .commitValid   (commitValid),
        .commit        (commit),
        .flush         (flush),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

endmodule

//--- rtl/execute.sv
`timescale 1ns/100ps

module execute
    import cpuPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    input  logic  issueValid,
    input  issueT issue,
    output cdbT   cdb
);

    dataT   opA;
    dataT   opB;
    dataT   linkPc;
    dataT   result;
    logic   jump;
    addrT   target;
    logic   validQ;
    robTagT tagQ;
    dataT   valueQ;
    logic   jumpQ;
    addrT   jumpPcQ;

    assign opA = issue.rs1Val;
    assign opB = issue.rs2Val;
    assign linkPc = issue.pc + 32'd4;

    always_comb begin
        result = '0;
        jump = 1'b0;
        target = issue.pc + issue.imm;    // branches and jal.
        case (issue.op)
            OP_LUI:   result = issue.imm;
            OP_AUIPC: result = issue.pc + issue.imm;
            OP_JAL: begin
                result = linkPc;
                jump = 1'b1;
            end
            OP_JALR: begin
                result = linkPc;
                jump = 1'b1;
                target = (opA + issue.imm) & ~32'd1;
            end
            OP_BEQ:   jump = opA == opB;
            OP_BNE:   jump = opA != opB;
            OP_BLT:   jump = $signed(opA) < $signed(opB);
            OP_BGE:   jump = $signed(opA) >= $signed(opB);
            OP_BLTU:  jump = opA < opB;
            OP_BGEU:  jump = opA >= opB;
            OP_ADDI:  result = opA + issue.imm;
            OP_SLTI:  result = {31'b0, $signed(opA) < $signed(issue.imm)};
            OP_SLTIU: result = {31'b0, opA < issue.imm};
            OP_XORI:  result = opA ^ issue.imm;
            OP_ORI:   result = opA | issue.imm;
            OP_ANDI:  result = opA & issue.imm;
            OP_SLLI:  result = opA << issue.imm[4:0];
            OP_SRLI:  result = opA >> issue.imm[4:0];
            OP_SRAI:  result = $signed(opA) >>> issue.imm[4:0];
            OP_ADD:   result = opA + opB;
            OP_SUB:   result = opA - opB;
            OP_SLL:   result = opA << opB[4:0];
            OP_SLT:   result = {31'b0, $signed(opA) < $signed(opB)};
            OP_SLTU:  result = {31'b0, opA < opB};
            OP_XOR:   result = opA ^ opB;
            OP_SRL:   result = opA >> opB[4:0];
            OP_SRA:   result = $signed(opA) >>> opB[4:0];
            OP_OR:    result = opA | opB;
            OP_AND:   result = opA & opB;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validQ <= 1'b0;    // drop whatever was in flight.
        end else begin
            validQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            tagQ <= issue.tag;
            valueQ <= result;
            jumpQ <= jump;
            jumpPcQ <= target;
        end
    end

    assign cdb = '{valid: validQ, tag: tagQ, value: valueQ, jump: jumpQ, jumpPc: jumpPcQ};

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the aluCluster testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module aluClusterTb \
    -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
else
    exit 1
fi
